// ==== egress_params.svh ====
////////////////////
// Sizes and limits of the egress stage, shared by the packages, the RTL and the testbench
////////////////////

`ifndef EGRESS_PARAMS_SVH
`define EGRESS_PARAMS_SVH

// Input stream
`define EGR_IN_BYTES       8
`define EGR_MAX_PKT_WORDS  8

// Output ports, narrow ones take the low port numbers
`define EGR_NUM_PORTS      4
`define EGR_NUM_NARROW     2
`define EGR_NARROW_BYTES   1
`define EGR_WIDE_BYTES     4

// Per-port buffering and statistics
`define EGR_FIFO_DEPTH     16
`define EGR_CNT_WIDTH      16

`endif

// ==== egress_stream_pkg.sv ====
////////////////////
// Types of the 64-bit packet stream and of the word buffers it fills
////////////////////

`default_nettype none

`include "egress_params.svh"

package egress_stream_pkg;

    // One input word and its byte enables
    typedef logic [`EGR_IN_BYTES*8-1:0] word_t;
    typedef logic [`EGR_IN_BYTES-1:0]   keep_t;

    // Buffer occupancy or free space, one extra bit so a full count fits
    typedef logic [$clog2(`EGR_FIFO_DEPTH):0] fifo_level_t;

endpackage

`default_nettype wire

// ==== egress_port_pkg.sv ====
////////////////////
// Types for port selection, per-port control and the egress state machines
////////////////////

`default_nettype none

`include "egress_params.svh"

package egress_port_pkg;

    typedef logic [$clog2(`EGR_NUM_PORTS)-1:0] port_id_t;
    typedef logic [`EGR_NUM_PORTS-1:0]         port_mask_t;
    typedef logic [`EGR_CNT_WIDTH-1:0]         pkt_count_t;

    // Width downsizer, LAST means the beat on the output is the final one of its word
    typedef enum logic [1:0] {
        DSZ_IDLE,
        DSZ_SHIFT,
        DSZ_LAST
    } dsz_state_t;

    // Packet steering, the fate of a packet is fixed at its head
    typedef enum logic [1:0] {
        DMX_HEAD,
        DMX_PASS,
        DMX_DROP
    } demux_state_t;

endpackage

`default_nettype wire

// ==== axis_word_if.sv ====
////////////////////
// One 64-bit packet stream with valid/ready handshake
////////////////////

`timescale 1ns/1ps
`default_nettype none

interface axis_word_if import egress_stream_pkg::*; ();

    word_t data;
    keep_t keep;
    logic  last;
    logic  valid;
    logic  ready;

    // Driving side, payload holds from valid until the transfer
    modport src (
        output data,
        output keep,
        output last,
        output valid,
        input  ready
    );

    modport snk (
        input  data,
        input  keep,
        input  last,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// ==== port_fifo.sv ====
////////////////////
// Word buffer of one port channel, reports its free space to the demux
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "egress_params.svh"

module port_fifo import egress_stream_pkg::*; (
    input  logic        core_clk_ifc,
    input  logic        rst,
    axis_word_if.snk    wr,
    axis_word_if.src    rd,
    output fifo_level_t free_words
);

    localparam int          DEPTH      = `EGR_FIFO_DEPTH;
    localparam int          AW         = $clog2(DEPTH);
    localparam fifo_level_t EMPTY_FREE = fifo_level_t'(DEPTH);

    word_t         mem_data [DEPTH];
    keep_t         mem_keep [DEPTH];
    logic          mem_last [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    fifo_level_t   free_q;
    logic          push;
    logic          pop;

    // The demux checks room per packet, so the write side never stalls
    assign wr.ready = 1'b1;
    assign push     = wr.valid && wr.ready;
    assign pop      = rd.valid && rd.ready;

    always_ff @(posedge core_clk_ifc) begin
        if (push) begin
            mem_data[wr_ptr] <= wr.data;
            mem_keep[wr_ptr] <= wr.keep;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            free_q <= EMPTY_FREE;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   free_q <= free_q - 1'b1;
                2'b01:   free_q <= free_q + 1'b1;
                default: free_q <= free_q;
            endcase
        end
    end

    // Head word is read from the storage registers at the read pointer
    assign rd.valid   = (free_q != EMPTY_FREE);
    assign rd.data    = mem_data[rd_ptr];
    assign rd.keep    = mem_keep[rd_ptr];
    assign rd.last    = mem_last[rd_ptr];
    assign free_words = free_q;

    a_no_write_full: assert property (
        @(posedge core_clk_ifc) disable iff (rst)
        wr.valid |-> free_q != '0
    ) else $error("write to full port buffer");

endmodule

`default_nettype wire

// ==== egress_port.sv ====
////////////////////
// One output port, buffers input words and emits them PORT_BYTES at a time
////////////////////

`timescale 1ns/1ps
`default_nettype none

module egress_port import egress_stream_pkg::*, egress_port_pkg::*; #(
    parameter int PORT_BYTES = 4
) (
    input  logic                    core_clk_ifc,
    input  logic                    rst,
    input  logic                    cnt_clear,
    axis_word_if.snk                in_word,
    output fifo_level_t             free_words,
    output logic                    out_valid,
    output logic [8*PORT_BYTES-1:0] out_data,
    output logic [PORT_BYTES-1:0]   out_keep,
    output logic                    out_last,
    input  logic                    out_ready,
    output pkt_count_t              pkt_cnt
);

    localparam int BEAT_BITS = 8 * PORT_BYTES;

    dsz_state_t state;
    word_t      hold_data;
    keep_t      hold_keep;
    logic       hold_last;
    word_t      shift_data;
    keep_t      shift_keep;
    logic       beat_done;
    logic       load;

    axis_word_if fifo_out ();

    port_fifo i_fifo (
        .core_clk_ifc (core_clk_ifc),
        .rst          (rst),
        .wr           (in_word),
        .rd           (fifo_out),
        .free_words   (free_words)
    );

    ////////////////////
    // Downsizer

    // Current beat sits in the low bytes of the held word
    assign out_valid = (state != DSZ_IDLE);
    assign out_data  = hold_data[BEAT_BITS-1:0];
    assign out_keep  = hold_keep[PORT_BYTES-1:0];
    assign out_last  = (state == DSZ_LAST) && hold_last;
    assign beat_done = out_valid && out_ready;

    // Next word is taken while the final beat of the current one leaves
    assign fifo_out.ready = (state == DSZ_IDLE) || ((state == DSZ_LAST) && out_ready);
    assign load           = fifo_out.valid && fifo_out.ready;

    assign shift_data = hold_data >> BEAT_BITS;
    assign shift_keep = hold_keep >> PORT_BYTES;

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            state <= DSZ_IDLE;
        end else if (load) begin
            // Kept bytes beyond the first beat mean more shifting
            if ((fifo_out.keep >> PORT_BYTES) != '0) begin
                state <= DSZ_SHIFT;
            end else begin
                state <= DSZ_LAST;
            end
        end else if (beat_done) begin
            if (state == DSZ_SHIFT) begin
                if ((shift_keep >> PORT_BYTES) != '0) begin
                    state <= DSZ_SHIFT;
                end else begin
                    state <= DSZ_LAST;
                end
            end else begin
                state <= DSZ_IDLE;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (load) begin
            hold_data <= fifo_out.data;
            hold_keep <= fifo_out.keep;
            hold_last <= fifo_out.last;
        end else if (beat_done && (state == DSZ_SHIFT)) begin
            hold_data <= shift_data;
            hold_keep <= shift_keep;
        end
    end

    ////////////////////
    // Packet counter

    // Clear takes priority over a count in the same cycle
    always_ff @(posedge core_clk_ifc) begin
        if (rst || cnt_clear) begin
            pkt_cnt <= '0;
        end else if (beat_done && out_last) begin
            pkt_cnt <= pkt_cnt + 1'b1;
        end
    end

    a_hold_beat: assert property (
        @(posedge core_clk_ifc) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data)
    ) else $error("output beat changed while stalled");

endmodule

`default_nettype wire

// ==== egress_demux.sv ====
////////////////////
// Steers input packets to the port channels, drops packets for disabled or full ports
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "egress_params.svh"

module egress_demux import egress_stream_pkg::*, egress_port_pkg::*; (
    input  logic        core_clk_ifc,
    input  logic        rst,
    input  logic        in_valid,
    input  word_t       in_data,
    input  keep_t       in_keep,
    input  logic        in_last,
    input  port_id_t    in_port,
    input  port_mask_t  port_enable,
    input  fifo_level_t free_words [`EGR_NUM_PORTS],
    axis_word_if.src    chan [`EGR_NUM_PORTS],
    output port_mask_t  buf_ready,
    output port_mask_t  buf_full_drop
);

    localparam fifo_level_t PKT_ROOM = fifo_level_t'(`EGR_MAX_PKT_WORDS);

    demux_state_t state;
    port_id_t     dest_q;
    port_mask_t   room;
    logic         head;
    logic         head_pass;
    port_id_t     sel_port;
    logic         sel_pass;

    // A port has room when a maximum-size packet still fits
    always_comb begin
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            room[p] = (free_words[p] >= PKT_ROOM);
        end
    end

    assign head      = (state == DMX_HEAD);
    assign head_pass = port_enable[in_port] && room[in_port];

    // Head word steers on its own port field, the rest follow the latched one
    assign sel_port = head ? in_port : dest_q;
    assign sel_pass = head ? head_pass : (state == DMX_PASS);

    ////////////////////
    // Packet FSM

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            state         <= DMX_HEAD;
            dest_q        <= '0;
            buf_ready     <= '1;
            buf_full_drop <= '0;
        end else begin
            buf_ready     <= room;
            buf_full_drop <= '0;
            if (in_valid) begin
                case (state)
                    DMX_HEAD: begin
                        dest_q <= in_port;
                        // Disabled ports drop silently, full ones raise the flag
                        if (port_enable[in_port] && !room[in_port]) begin
                            buf_full_drop[in_port] <= 1'b1;
                        end
                        if (!in_last) begin
                            state <= head_pass ? DMX_PASS : DMX_DROP;
                        end
                    end
                    default: begin
                        if (in_last) begin
                            state <= DMX_HEAD;
                        end
                    end
                endcase
            end
        end
    end

    ////////////////////
    // Channel drive

    for (genvar p = 0; p < `EGR_NUM_PORTS; p++) begin : g_chan
        assign chan[p].valid = in_valid && sel_pass && (sel_port == port_id_t'(p));
        assign chan[p].data  = in_data;
        assign chan[p].keep  = in_keep;
        assign chan[p].last  = in_last;

        // Room check at the head must cover every word of the packet
        a_no_overflow: assert property (
            @(posedge core_clk_ifc) disable iff (rst)
            chan[p].valid && chan[p].ready |-> free_words[p] != '0
        ) else $error("word written to full buffer on port %0d", p);
    end

endmodule

`default_nettype wire

// ==== egress_top.sv ====
////////////////////
// Egress stage top, one 64-bit input steered to two 8-bit and two 32-bit output ports
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "egress_params.svh"

module egress_top import egress_stream_pkg::*, egress_port_pkg::*; (
    input  logic        core_clk_ifc,
    input  logic        rst,

    // Input stream, no back-pressure
    input  logic        in_valid,
    input  word_t       in_data,
    input  keep_t       in_keep,
    input  logic        in_last,
    input  port_id_t    in_port,

    // Control and status
    input  port_mask_t  port_enable,
    input  port_mask_t  cnt_clear,
    output port_mask_t  buf_ready,
    output port_mask_t  buf_full_drop,
    output pkt_count_t  pkt_cnt [`EGR_NUM_PORTS],

    // Narrow ports
    output logic [`EGR_NUM_NARROW-1:0]        nb_valid,
    output logic [8*`EGR_NARROW_BYTES-1:0]    nb_data [`EGR_NUM_NARROW],
    output logic [`EGR_NUM_NARROW-1:0]        nb_last,
    input  logic [`EGR_NUM_NARROW-1:0]        nb_ready,

    // Wide ports
    output logic [`EGR_NUM_PORTS-`EGR_NUM_NARROW-1:0] wb_valid,
    output logic [8*`EGR_WIDE_BYTES-1:0] wb_data [`EGR_NUM_PORTS-`EGR_NUM_NARROW],
    output logic [`EGR_WIDE_BYTES-1:0]   wb_keep [`EGR_NUM_PORTS-`EGR_NUM_NARROW],
    output logic [`EGR_NUM_PORTS-`EGR_NUM_NARROW-1:0] wb_last,
    input  logic [`EGR_NUM_PORTS-`EGR_NUM_NARROW-1:0] wb_ready
);

    fifo_level_t free_words [`EGR_NUM_PORTS];

    axis_word_if chan [`EGR_NUM_PORTS] ();

    egress_demux i_demux (
        .core_clk_ifc  (core_clk_ifc),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_keep       (in_keep),
        .in_last       (in_last),
        .in_port       (in_port),
        .port_enable   (port_enable),
        .free_words    (free_words),
        .chan          (chan),
        .buf_ready     (buf_ready),
        .buf_full_drop (buf_full_drop)
    );

    ////////////////////
    // Port channels

    for (genvar n = 0; n < `EGR_NUM_NARROW; n++) begin : g_narrow
        // Single-byte beats carry no byte enable
        egress_port #(
            .PORT_BYTES (`EGR_NARROW_BYTES)
        ) i_port (
            .core_clk_ifc (core_clk_ifc),
            .rst          (rst),
            .cnt_clear    (cnt_clear[n]),
            .in_word      (chan[n]),
            .free_words   (free_words[n]),
            .out_valid    (nb_valid[n]),
            .out_data     (nb_data[n]),
            .out_keep     (),
            .out_last     (nb_last[n]),
            .out_ready    (nb_ready[n]),
            .pkt_cnt      (pkt_cnt[n])
        );
    end

    for (genvar w = 0; w < `EGR_NUM_PORTS - `EGR_NUM_NARROW; w++) begin : g_wide
        egress_port #(
            .PORT_BYTES (`EGR_WIDE_BYTES)
        ) i_port (
            .core_clk_ifc (core_clk_ifc),
            .rst          (rst),
            .cnt_clear    (cnt_clear[`EGR_NUM_NARROW + w]),
            .in_word      (chan[`EGR_NUM_NARROW + w]),
            .free_words   (free_words[`EGR_NUM_NARROW + w]),
            .out_valid    (wb_valid[w]),
            .out_data     (wb_data[w]),
            .out_keep     (wb_keep[w]),
            .out_last     (wb_last[w]),
            .out_ready    (wb_ready[w]),
            .pkt_cnt      (pkt_cnt[`EGR_NUM_NARROW + w])
        );
    end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
////////////////////
// Testbench clock and synchronous reset, reset held high for the first cycles
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            clk = ~clk;
        end
    end

    // Release just after an edge, like the other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_egress.sv ====
////////////////////
// Testbench of the egress stage that runs each step of egress_testdata.txt
// against egress_top and checks every output port
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "egress_params.svh"

module tb_egress import egress_stream_pkg::*, egress_port_pkg::*; ();

    localparam int NP          = `EGR_NUM_PORTS;
    localparam int NN          = `EGR_NUM_NARROW;
    localparam int NW          = `EGR_NUM_PORTS - `EGR_NUM_NARROW;
    localparam int DRAIN_LIMIT = 2000;
    localparam int FILL_LIMIT  = 20;
    localparam int RESET_LIMIT = 20;
    localparam int CLEAR_PORT  = 2;

    logic          clk;
    logic          rst;
    logic          in_valid;
    word_t         in_data;
    keep_t         in_keep;
    logic          in_last;
    port_id_t      in_port;
    port_mask_t    port_enable;
    port_mask_t    cnt_clear;
    port_mask_t    buf_ready;
    port_mask_t    buf_full_drop;
    pkt_count_t    pkt_cnt [NP];
    logic [NN-1:0] nb_valid;
    logic [7:0]    nb_data [NN];
    logic [NN-1:0] nb_last;
    logic [NN-1:0] nb_ready;
    logic [NW-1:0] wb_valid;
    logic [31:0]   wb_data [NW];
    logic [3:0]    wb_keep [NW];
    logic [NW-1:0] wb_last;
    logic [NW-1:0] wb_ready;

    // Expected bytes per port with a flag on the final byte of each packet
    logic [7:0]    exp_bytes [NP][$];
    logic          exp_last  [NP][$];
    pkt_count_t    model_cnt [NP];
    int            drop_cnt  [NP];
    int            drop_base [NP];
    int            error_cnt;
    int            test_cnt;
    int            fail_cnt;

    tb_clk_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (2)
    ) i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    egress_top i_dut (
        .core_clk_ifc  (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_keep       (in_keep),
        .in_last       (in_last),
        .in_port       (in_port),
        .port_enable   (port_enable),
        .cnt_clear     (cnt_clear),
        .buf_ready     (buf_ready),
        .buf_full_drop (buf_full_drop),
        .pkt_cnt       (pkt_cnt),
        .nb_valid      (nb_valid),
        .nb_data       (nb_data),
        .nb_last       (nb_last),
        .nb_ready      (nb_ready),
        .wb_valid      (wb_valid),
        .wb_data       (wb_data),
        .wb_keep       (wb_keep),
        .wb_last       (wb_last),
        .wb_ready      (wb_ready)
    );

    ////////////////////
    // Compare tasks

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got_data,
                              input logic [3:0] got_keep, input logic [31:0] exp_data,
                              input logic [3:0] exp_keep);
        if (got_data !== exp_data || got_keep !== exp_keep) begin
            $display("[ERROR] %s: got data 0x%h keep 0x%h, expected data 0x%h keep 0x%h",
                     name, got_data, got_keep, exp_data, exp_keep);
            error_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic check_count(input string name, input pkt_count_t got, input pkt_count_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic check_mask(input string name, input port_mask_t got, input port_mask_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            error_cnt++;
        end
    endtask

    ////////////////////
    // Output monitor

    always @(posedge clk) begin : monitor
        logic [31:0] exp_word;
        logic [3:0]  exp_keep;
        logic        exp_l;
        logic [31:0] kept;
        int          p;
        int          k;
        if (!rst) begin
            for (int n = 0; n < NP; n++) begin
                if (buf_full_drop[n]) begin
                    drop_cnt[n]++;
                end
            end
            for (int n = 0; n < NN; n++) begin
                if (nb_valid[n] && nb_ready[n]) begin
                    if (exp_bytes[n].size() == 0) begin
                        $display("Port %0d sent a beat while no data was expected", n);
                        error_cnt++;
                    end else begin
                        check_byte($sformatf("nb_data[%0d]", n), nb_data[n],
                                   exp_bytes[n].pop_front());
                        check_flag($sformatf("nb_last[%0d]", n), nb_last[n],
                                   exp_last[n].pop_front());
                    end
                end
            end
            for (int w = 0; w < NW; w++) begin
                p = NN + w;
                if (wb_valid[w] && wb_ready[w]) begin
                    if (exp_bytes[p].size() == 0) begin
                        $display("Port %0d sent a beat while no data was expected", p);
                        error_cnt++;
                    end else begin
                        exp_word = '0;
                        exp_keep = '0;
                        exp_l    = 1'b0;
                        k        = 0;
                        // A beat takes up to four bytes and never crosses a packet end
                        while (k < 4 && exp_bytes[p].size() != 0 && !exp_l) begin
                            exp_word[8*k +: 8] = exp_bytes[p].pop_front();
                            exp_l              = exp_last[p].pop_front();
                            exp_keep[k]        = 1'b1;
                            k++;
                        end
                        for (int b = 0; b < 4; b++) begin
                            kept[8*b +: 8] = wb_keep[w][b] ? wb_data[w][8*b +: 8] : 8'h00;
                        end
                        check_word($sformatf("wb_data/wb_keep[%0d]", w), kept, wb_keep[w],
                                   exp_word, exp_keep);
                        check_flag($sformatf("wb_last[%0d]", w), wb_last[w], exp_l);
                    end
                end
            end
        end
    end

    ////////////////////
    // Stimulus helpers

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) step();
    endtask

    task automatic set_ready(input int port, input logic val);
        if (port < NN) begin
            nb_ready[port] = val;
        end else begin
            wb_ready[port-NN] = val;
        end
    endtask

    task automatic send_packet(input int port, input int len, input bit deliver);
        int         nwords;
        int         idx;
        logic [7:0] b;
        nwords = (len + 7) / 8;
        for (int w = 0; w < nwords; w++) begin
            in_data = '0;
            in_keep = '0;
            for (int i = 0; i < 8; i++) begin
                idx = w * 8 + i;
                if (idx < len) begin
                    b                 = 8'($urandom);
                    in_data[8*i +: 8] = b;
                    in_keep[i]        = 1'b1;
                    if (deliver) begin
                        exp_bytes[port].push_back(b);
                        exp_last[port].push_back(idx == len - 1);
                    end
                end
            end
            in_valid = 1'b1;
            in_last  = (w == nwords - 1);
            in_port  = port_id_t'(port);
            step();
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    function automatic bit queues_empty();
        bit empty;
        empty = 1'b1;
        for (int p = 0; p < NP; p++) begin
            if (exp_bytes[p].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (!queues_empty() && cycles < DRAIN_LIMIT) begin
            step();
            cycles++;
        end
        if (!queues_empty()) begin
            $display("Timeout: expected output still missing after %0d cycles", DRAIN_LIMIT);
            error_cnt++;
            for (int p = 0; p < NP; p++) begin
                exp_bytes[p].delete();
                exp_last[p].delete();
            end
        end
        // Margin for a stray beat or a late count
        idle(4);
    endtask

    task automatic mark_drops();
        for (int p = 0; p < NP; p++) begin
            drop_base[p] = drop_cnt[p];
        end
    endtask

    function automatic port_mask_t new_drops();
        port_mask_t m;
        for (int p = 0; p < NP; p++) begin
            m[p] = (drop_cnt[p] != drop_base[p]);
        end
        return m;
    endfunction

    task automatic check_all_counts();
        for (int p = 0; p < NP; p++) begin
            check_count($sformatf("pkt_cnt[%0d]", p), pkt_cnt[p], model_cnt[p]);
        end
    endtask

    task automatic log_result(input int tid, input int err_before);
        test_cnt++;
        if (error_cnt == err_before) begin
            $display("test %0d: passed", tid);
        end else begin
            fail_cnt++;
            $display("test %0d: failed with %0d errors", tid, error_cnt - err_before);
        end
    endtask

    ////////////////////
    // Test kinds

    task automatic run_normal(input int port, input int len);
        bit deliver;
        deliver = port_enable[port];
        mark_drops();
        send_packet(port, len, deliver);
        if (deliver) begin
            model_cnt[port]++;
        end
        wait_drained();
        check_mask("buf_full_drop", new_drops(), '0);
        check_all_counts();
    endtask

    task automatic run_stall(input int port, input int len);
        int sent;
        sent = 0;
        set_ready(port, 1'b0);
        mark_drops();
        while (buf_ready[port] && sent < FILL_LIMIT) begin
            send_packet(port, len, 1'b1);
            model_cnt[port]++;
            sent++;
            idle(2);
        end
        if (buf_ready[port]) begin
            $display("buf_ready of port %0d stayed high after %0d packets", port, sent);
            error_cnt++;
        end
        check_mask("buf_ready", buf_ready, ~(port_mask_t'(1) << port));
        check_mask("buf_full_drop", new_drops(), '0);
        // This packet meets a low buf_ready and must be flagged and dropped
        send_packet(port, len, 1'b0);
        idle(2);
        check_mask("buf_full_drop", new_drops(), port_mask_t'(1) << port);
        set_ready(port, 1'b1);
        wait_drained();
        check_mask("buf_ready", buf_ready, '1);
        check_all_counts();
    endtask

    ////////////////////
    // Main sequence

    initial begin : main
        int    fd;
        int    code;
        string line;
        int    tid;
        int    tport;
        int    tlen;
        int    ten;
        int    tmode;
        int    texp;
        int    err_before;
        int    cycles;
        void'($urandom(32'h16a5));
        error_cnt   = 0;
        test_cnt    = 0;
        fail_cnt    = 0;
        tid         = 0;
        in_valid    = 1'b0;
        in_data     = '0;
        in_keep     = '0;
        in_last     = 1'b0;
        in_port     = '0;
        port_enable = '1;
        cnt_clear   = '0;
        nb_ready    = '1;
        wb_ready    = '1;
        for (int p = 0; p < NP; p++) begin
            model_cnt[p] = '0;
            drop_cnt[p]  = 0;
        end

        // Reset release is sampled on the clock edge
        cycles = 0;
        @(posedge clk);
        while (rst && cycles < RESET_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst) begin
            $display("Timeout: reset never released");
            error_cnt++;
        end
        step();

        // State right after reset
        err_before = error_cnt;
        check_mask("buf_ready", buf_ready, '1);
        check_mask("buf_full_drop", buf_full_drop, '0);
        check_mask("out_valid", {wb_valid, nb_valid}, '0);
        check_all_counts();
        log_result(0, err_before);

        fd = $fopen("egress_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open egress_testdata.txt");
            error_cnt++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code != 0 &&
                    $sscanf(line, "%h %h %h %h %h %h", tid, tport, tlen, ten, tmode, texp) == 6)
                begin
                    err_before  = error_cnt;
                    port_enable = port_mask_t'(ten);
                    if (tmode == 1) begin
                        run_stall(tport, tlen);
                    end else begin
                        run_normal(tport, tlen);
                    end
                    check_count($sformatf("pkt_cnt[%0d] against data file", tport),
                                pkt_cnt[tport], pkt_count_t'(texp));
                    log_result(tid, err_before);
                end
            end
            $fclose(fd);
        end

        // Clearing one counter leaves the others unchanged
        err_before = error_cnt;
        cnt_clear  = port_mask_t'(1) << CLEAR_PORT;
        step();
        cnt_clear  = '0;
        model_cnt[CLEAR_PORT] = '0;
        idle(1);
        check_all_counts();
        log_result(tid + 1, err_before);

        $display("Summary: %0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
egress_stream_pkg.sv
egress_port_pkg.sv
axis_word_if.sv
port_fifo.sv
egress_port.sv
egress_demux.sv
egress_top.sv
tb_clk_gen.sv
tb_egress.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_egress
FILELIST = build.f
LOG      = sim.log
PASS     = Test OK

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== egress_testdata.txt ====
// Columns in hex: test id, port, length in bytes, enable mask, ready mode, expected count
// Ready mode 0 keeps the output ready, 1 stalls it until the buffer drops a packet
01 0 01 f 0 01
02 1 40 f 0 01
03 2 05 f 0 01
04 3 08 f 0 01
05 0 11 f 0 02
06 1 03 f 0 02
07 2 40 f 0 02
08 3 1e f 0 02
09 2 07 f 0 03
0a 3 0c f 0 03
0b 1 24 d 0 02
0c 0 09 d 0 03
0d 3 10 7 0 03
0e 2 21 7 0 04
0f 3 40 f 1 05
10 0 40 f 1 05
11 2 20 f 1 07
12 1 0f f 0 03
13 1 40 f 1 05
